// File: filelist.f
hdl/crc_pkg.sv
hdl/crc_cfg_if.sv
hdl/host_interface.sv
hdl/crc_unit.sv
hdl/crc_ahb_top.sv
test/crc_ahb_checker.sv
test/crc_ahb_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CRC AHB-Lite testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module crc_ahb_tb \
	-f filelist.f -Mdir obj_dir -o crc_ahb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/crc_ahb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: test/crc_ahb_input.txt
# name op addr size wdata expect, hex except size 0 byte 1 halfword 2 word
# op W write, R read and check, N unselected, S SEQ, I IDLE, B BUSY write
rst_init  R 00000010 2 00000000 ffffffff
rst_pol   R 00000014 2 00000000 04c11db7
rst_idr   R 00000004 2 00000000 00000000
rst_cr    R 00000008 2 00000000 00000000
rst_dr    R 00000000 2 00000000 ffffffff
reg_idr   W 00000004 2 12345678 00000000
reg_idr   R 00000004 2 00000000 00000078
reg_pol   W 00000014 2 deadbeef 00000000
reg_pol   R 00000014 2 00000000 deadbeef
reg_init  W 00000010 2 89abcdef 00000000
reg_init  R 00000010 2 00000000 89abcdef
reg_cr    W 00000008 2 000000f9 00000000
reg_cr    R 00000008 2 00000000 000000f8
reg_dr    R 00000000 2 00000000 0000007b
reg_init  W 00000010 2 ffffffff 00000000
reg_pol   W 00000014 2 04c11db7 00000000
mpeg2     W 00000008 2 00000001 00000000
mpeg2     W 00000000 2 31323334 00000000
mpeg2     W 00000000 2 35363738 00000000
mpeg2     W 00000000 0 00000039 00000000
mpeg2     R 00000000 2 00000000 0376e6e7
rev_out   W 00000008 2 00000080 00000000
rev_out   R 00000000 2 00000000 e7676ec0
rev_byte  W 00000008 2 000000a1 00000000
rev_byte  W 00000000 2 31323334 00000000
rev_byte  W 00000000 2 35363738 00000000
rev_byte  W 00000000 0 00000039 00000000
rev_byte  R 00000000 2 00000000 340bc6d9
rev_half  W 00000008 2 000000c1 00000000
rev_half  W 00000000 1 00003231 00000000
rev_half  W 00000000 1 00003433 00000000
rev_half  W 00000000 1 00003635 00000000
rev_half  W 00000000 1 00003837 00000000
rev_half  W 00000000 0 00000039 00000000
rev_half  R 00000000 2 00000000 340bc6d9
rev_word  W 00000008 2 000000e1 00000000
rev_word  W 00000000 0 00000031 00000000
rev_word  W 00000000 2 35343332 00000000
rev_word  W 00000000 2 39383736 00000000
rev_word  R 00000000 2 00000000 340bc6d9
crc16     W 00000014 2 00001021 00000000
crc16     W 00000010 2 0000ffff 00000000
crc16     W 00000008 2 00000009 00000000
crc16     W 00000000 1 00003132 00000000
crc16     W 00000000 1 00003334 00000000
crc16     W 00000000 1 00003536 00000000
crc16     W 00000000 1 00003738 00000000
crc16     W 00000000 0 00000039 00000000
crc16     R 00000000 2 00000000 000029b1
crc8      W 00000014 2 00000007 00000000
crc8      W 00000010 2 00000000 00000000
crc8      W 00000008 2 00000011 00000000
crc8      W 00000000 2 31323334 00000000
crc8      W 00000000 2 35363738 00000000
crc8      W 00000000 0 00000039 00000000
crc8      R 00000000 2 00000000 000000f4
crc7      W 00000014 2 00000009 00000000
crc7      W 00000010 2 00000000 00000000
crc7      W 00000008 2 00000019 00000000
crc7      W 00000000 2 31323334 00000000
crc7      W 00000000 1 00003536 00000000
crc7      W 00000000 1 00003738 00000000
crc7      W 00000000 0 00000039 00000000
crc7      R 00000000 2 00000000 00000075
inactive  N 00000004 2 00000011 00000000
inactive  S 00000004 2 00000022 00000000
inactive  I 00000004 2 00000033 00000000
inactive  B 00000004 2 00000044 00000000
inactive  R 00000004 2 00000000 00000078

// File: test/crc_ahb_tb.sv
////////////////////////////////////////
// Testbench for the CRC AHB-Lite slave
// Stimulus file path is relative, run from the project root
// One transfer at a time, address phases are not overlapped
// HREADY is tied high, the slave is alone on the bus
////////////////////////////////////////
module crc_ahb_tb import crc_pkg::*;
();

	localparam string STIM_FILE = "test/crc_ahb_input.txt";

	logic        HCLK = 1'b0;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	htrans_t     HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	int cycle_count = 0;
	int cycle_limit = 100;

	crc_ahb_top #(
		.RESET_INIT (32'hFFFF_FFFF),
		.RESET_POLY (32'h04C1_1DB7)
	) DUT (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	always #4 HCLK = ~HCLK;

	////////////////////////////////////////
	// Timeout
	////////////////////////////////////////

	always @(posedge HCLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d clock cycles, the DUT stopped responding", cycle_count);
			$display("TEST FAILED");
			$fatal(1, "Simulation timeout");
		end
	end

	////////////////////////////////////////
	// Bus driver and compare
	////////////////////////////////////////

	// Address phase, then data phase until HREADYOUT is seen high
	task automatic bus_transfer(input logic sel, input htrans_t trans, input logic wr,
	                            input logic [31:0] addr, input logic [2:0] size,
	                            input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge HCLK);
		HSElx  <= sel;
		HTRANS <= trans;
		HWRITE <= wr;
		HADDR  <= addr;
		HSIZE  <= size;
		@(posedge HCLK);
		// Next address phase is idle
		HSElx  <= 1'b0;
		HTRANS <= IDLE;
		HWRITE <= 1'b0;
		HWDATA <= wdata;
		// HREADYOUT sampled mid cycle
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		rdata = HRDATA;
	endtask

	task automatic compare_word(input logic [8*16-1:0] name, input logic [31:0] expected,
	                            input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERR %0s expected %08h actual %08h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Read data mismatch");
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		int               fd;
		int               n_lines;
		int               n_reads;
		logic [8*128-1:0] line;
		logic [8*16-1:0]  name;
		logic [7:0]       op;
		logic [31:0]      addr;
		logic [2:0]       size;
		logic [31:0]      wdata;
		logic [31:0]      exp_data;
		logic [31:0]      rdata;

		HRESETn <= 1'b0;
		HSElx   <= 1'b0;
		HADDR   <= 32'h0;
		HTRANS  <= IDLE;
		HSIZE   <= 3'd2;
		HWRITE  <= 1'b0;
		HWDATA  <= 32'h0;
		HREADY  <= 1'b1;

		// First pass only counts transfers for the timeout
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file %s", STIM_FILE);
			$display("TEST FAILED");
			$fatal(1, "Missing stimulus file");
		end
		n_lines = 0;
		while ($fgets(line, fd) != 0)
		begin
			if ($sscanf(line, "%s %s %h %d %h %h", name, op, addr, size, wdata, exp_data) == 6)
				n_lines++;
		end
		$fclose(fd);
		cycle_limit = n_lines * 16 + 100;

		repeat (4) @(posedge HCLK);
		HRESETn <= 1'b1;

		fd = $fopen(STIM_FILE, "r");
		n_reads = 0;
		while ($fgets(line, fd) != 0)
		begin
			// Comment and blank lines do not give six fields
			if ($sscanf(line, "%s %s %h %d %h %h", name, op, addr, size, wdata, exp_data) == 6)
			begin
				case (op)
					"W": bus_transfer(1'b1, NONSEQ, 1'b1, addr, size, wdata, rdata);
					"R":
					begin
						bus_transfer(1'b1, NONSEQ, 1'b0, addr, size, 32'h0, rdata);
						compare_word(name, exp_data, rdata);
						n_reads++;
					end
					// Writes the slave must ignore
					"N": bus_transfer(1'b0, NONSEQ, 1'b1, addr, size, wdata, rdata);
					"S": bus_transfer(1'b1, SEQ, 1'b1, addr, size, wdata, rdata);
					"I": bus_transfer(1'b1, IDLE, 1'b1, addr, size, wdata, rdata);
					"B": bus_transfer(1'b1, BUSY, 1'b1, addr, size, wdata, rdata);
					default:
					begin
						$display("Unknown operation in the stimulus line of %0s", name);
						$display("TEST FAILED");
						$fatal(1, "Bad stimulus line");
					end
				endcase
			end
		end
		$fclose(fd);

		// Let the last data phase finish
		@(posedge HCLK);
		if (n_reads == 0)
		begin
			$display("The stimulus file holds no read checks");
			$display("TEST FAILED");
			$fatal(1, "Empty stimulus");
		end
		else
		begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// File: test/crc_ahb_checker.sv
////////////////////////////////////////
// Protocol checks for host_interface
// Bound to every host_interface instance
// Nothing is checked while HRESETn is low
////////////////////////////////////////
module crc_ahb_checker
(
	input logic HCLK,
	input logic HRESETn,
	input logic HRESP,
	input logic HREADYOUT,
	input logic dr_rd,
	input logic read_wait,
	input logic buffer_write_en,
	input logic crc_init_en,
	input logic crc_idr_en,
	input logic crc_poly_en,
	input logic reset_chain
);

	logic [4:0] strobes;

	assign strobes = {buffer_write_en, crc_init_en, crc_idr_en, crc_poly_en, reset_chain};

	// Slave has no error response
	a_hresp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn) !HRESP)
		else $error("HRESP is not OKAY");

	// One register write per data phase
	a_one_strobe: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(strobes))
		else $error("More than one write strobe is active");

	// Result is not returned while the engine is busy
	a_read_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_rd && read_wait) |-> !HREADYOUT)
		else $error("DR read completed while read_wait was high");

endmodule

bind host_interface crc_ahb_checker u_checker (
	.HCLK            (HCLK),
	.HRESETn         (HRESETn),
	.HRESP           (HRESP),
	.HREADYOUT       (HREADYOUT),
	.dr_rd           (dr_rd),
	.read_wait       (cfg.read_wait),
	.buffer_write_en (cfg.buffer_write_en),
	.crc_init_en     (cfg.crc_init_en),
	.crc_idr_en      (cfg.crc_idr_en),
	.crc_poly_en     (cfg.crc_poly_en),
	.reset_chain     (cfg.reset_chain)
);

// File: hdl/crc_ahb_top.sv
////////////////////////////////////////
// CRC calculation unit on an AHB-Lite slave port
// RESET_INIT and RESET_POLY only set reset contents
////////////////////////////////////////
module crc_ahb_top import crc_pkg::*;
#(
	parameter logic [31:0] RESET_INIT = 32'hFFFF_FFFF,
	parameter logic [31:0] RESET_POLY = 32'h04C1_1DB7
)
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  htrans_t     HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	// Configuration, strobes and status between the two halves
	crc_cfg_if cfg ();

	// Bus side
	host_interface u_host (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP),
		.cfg       (cfg.host)
	);

	// CRC datapath
	crc_unit #(
		.RESET_INIT (RESET_INIT),
		.RESET_POLY (RESET_POLY)
	) u_unit (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.cfg     (cfg.unit)
	);

endmodule

// File: hdl/crc_unit.sv
////////////////////////////////////////
// Byte serial CRC engine with one word input buffer
// A word takes 1, 2 or 4 cycles depending on its size
// Input reversal never spans more than the written data,
// e.g. REV_WORD on a halfword mirrors the halfword
////////////////////////////////////////
module crc_unit import crc_pkg::*;
#(
	parameter logic [31:0] RESET_INIT = 32'hFFFF_FFFF,
	parameter logic [31:0] RESET_POLY = 32'h04C1_1DB7
)
(
	input  logic    HCLK,
	input  logic    HRESETn,
	crc_cfg_if.unit cfg
);

	crc_state_t  state_ff;
	logic [31:0] crc_ff;
	logic [31:0] buf_ff;
	logic [2:0]  cnt_ff;

	logic [31:0] init_ff;
	logic [31:0] poly_ff;
	logic [7:0]  idr_ff;

	logic [31:0] aligned;
	logic [2:0]  n_bytes;
	rev_in_t     rev_eff;
	logic [31:0] crc_next;
	logic [4:0]  top_bit;
	logic [31:0] width_mask;
	logic [4:0]  rev_shift;
	logic [31:0] crc_masked;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Mirror bits inside each byte, halfword or the whole word
	function automatic logic [31:0] mirror(input logic [31:0] d, input rev_in_t mode);
		logic [31:0] r;
		r = d;
		for (int i = 0; i < 32; i++)
		begin
			case (mode)
				REV_BYTE: r[i] = d[(i / 8) * 8 + 7 - (i % 8)];
				REV_HALF: r[i] = d[(i / 16) * 16 + 15 - (i % 16)];
				REV_WORD: r[i] = d[31 - i];
				default:  r[i] = d[i];
			endcase
		end
		return r;
	endfunction

	// One byte MSB first through the bitwise LFSR
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d,
	                                         input logic [31:0] poly, input logic [4:0] top);
		logic [31:0] r;
		logic        fb;
		r = c;
		for (int i = 7; i >= 0; i--)
		begin
			fb = d[i] ^ r[top];
			r  = {r[30:0], 1'b0};
			if (fb)
				r = r ^ poly;
		end
		return r;
	endfunction

	////////////////////////////////////////
	// Input path
	////////////////////////////////////////

	// Left align the written bytes so the first one sits in bits 31:24
	always_comb
	begin
		case (cfg.bus_size)
			2'd0:
			begin
				aligned = {cfg.bus_wr[7:0], 24'h0};
				n_bytes = 3'd1;
			end
			2'd1:
			begin
				aligned = {cfg.bus_wr[15:0], 16'h0};
				n_bytes = 3'd2;
			end
			default:
			begin
				aligned = cfg.bus_wr;
				n_bytes = 3'd4;
			end
		endcase
	end

	// Clip the reversal unit to the transfer size
	always_comb
	begin
		rev_eff = cfg.rev_in_type;
		if (cfg.bus_size == 2'd0 && rev_eff != REV_NONE)
			rev_eff = REV_BYTE;
		else if (cfg.bus_size == 2'd1 && rev_eff == REV_WORD)
			rev_eff = REV_HALF;
	end

	// Buffer shifts one byte out per cycle
	always_ff @(posedge HCLK)
	begin
		if (cfg.buffer_write_en)
			buf_ff <= mirror(aligned, rev_eff);
		else if (state_ff == ST_CALC)
			buf_ff <= {buf_ff[23:0], 8'h0};
	end

	////////////////////////////////////////
	// Engine
	////////////////////////////////////////

	always_comb
	begin
		case (cfg.crc_poly_size)
			POLY_16: {top_bit, width_mask, rev_shift} = {5'd15, 32'h0000_FFFF, 5'd16};
			POLY_8:  {top_bit, width_mask, rev_shift} = {5'd7, 32'h0000_00FF, 5'd24};
			POLY_7:  {top_bit, width_mask, rev_shift} = {5'd6, 32'h0000_007F, 5'd25};
			default: {top_bit, width_mask, rev_shift} = {5'd31, 32'hFFFF_FFFF, 5'd0};
		endcase
	end

	assign crc_next = crc_byte(crc_ff, buf_ff[31:24], poly_ff, top_bit);

	// Last byte may be processed in the same cycle a new word loads
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_ff <= ST_IDLE;
			cnt_ff   <= 3'd0;
			crc_ff   <= RESET_INIT;
		end
		else
		begin
			if (state_ff == ST_CALC)
				crc_ff <= crc_next;
			else if (state_ff == ST_LOAD)
				crc_ff <= init_ff;

			// Chain reset drops any bytes still in the buffer
			if (cfg.reset_chain)
			begin
				state_ff <= ST_LOAD;
				cnt_ff   <= 3'd0;
			end
			else if (cfg.buffer_write_en)
			begin
				state_ff <= ST_CALC;
				cnt_ff   <= n_bytes;
			end
			else if (state_ff == ST_CALC)
			begin
				cnt_ff <= cnt_ff - 3'd1;
				if (cnt_ff == 3'd1)
					state_ff <= ST_IDLE;
			end
			else if (state_ff == ST_LOAD)
				state_ff <= ST_IDLE;
		end
	end

	// Buffer frees up while its last byte goes through
	assign cfg.buffer_full   = (state_ff == ST_CALC) && (cnt_ff != 3'd1);
	// Result is stale while bytes remain or the chain reloads
	assign cfg.read_wait     = (state_ff != ST_IDLE);
	assign cfg.reset_pending = (state_ff == ST_LOAD);

	////////////////////////////////////////
	// Output and user registers
	////////////////////////////////////////

	assign crc_masked  = crc_ff & width_mask;
	assign cfg.crc_out = cfg.rev_out_type ? (mirror(crc_masked, REV_WORD) >> rev_shift)
	                                      : crc_masked;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_ff <= RESET_INIT;
			poly_ff <= RESET_POLY;
			idr_ff  <= 8'h00;
		end
		else
		begin
			if (cfg.crc_init_en)
				init_ff <= cfg.bus_wr;
			if (cfg.crc_poly_en)
				poly_ff <= cfg.bus_wr;
			// IDR keeps the low byte only
			if (cfg.crc_idr_en)
				idr_ff <= cfg.bus_wr[7:0];
		end
	end

	assign cfg.crc_init_out = init_ff;
	assign cfg.crc_poly_out = poly_ff;
	assign cfg.crc_idr_out  = idr_ff;

endmodule

// File: hdl/host_interface.sv
////////////////////////////////////////
// AHB-Lite slave front end of the CRC block
// Only NONSEQ beats are acted on, no burst address increment
// HRESP is always OKAY, HSIZE above word is treated as word
// Wait states only for DR and for INIT during a chain reload
////////////////////////////////////////
module host_interface import crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  htrans_t     HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	crc_cfg_if.host     cfg
);

	// Address phase pipeline
	logic        hselx_pp;
	htrans_t     htrans_pp;
	logic        hwrite_pp;
	crc_reg_t    haddr_pp;
	logic [1:0]  hsize_pp;

	// CR flops: rev_out, rev_in[1:0], poly_size[1:0]
	logic [4:0]  crc_cr_ff;

	logic        sample_bus;
	logic        write_en;
	logic        read_en;
	logic        dr_wr;
	logic        dr_rd;
	logic        init_wr;
	logic        ready;

	////////////////////////////////////////
	// Address phase
	////////////////////////////////////////

	// New address phase is taken only when the current data phase ends
	assign sample_bus = ready && HREADY;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= IDLE;
			hwrite_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	// Address and size are only looked at when hselx_pp is set
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= crc_reg_t'(HADDR[4:2]);
			hsize_pp <= HSIZE[1:0];
		end
	end

	////////////////////////////////////////
	// Data phase decode
	////////////////////////////////////////

	// SEQ, BUSY and IDLE beats do nothing
	assign write_en = hselx_pp && hwrite_pp && (htrans_pp == NONSEQ);
	assign read_en  = hselx_pp && !hwrite_pp && (htrans_pp == NONSEQ);

	assign dr_wr   = write_en && (haddr_pp == REG_DR);
	assign dr_rd   = read_en && (haddr_pp == REG_DR);
	assign init_wr = write_en && (haddr_pp == REG_INIT);

	// Stretch the data phase until the CRC unit can take it
	assign ready = !((dr_wr && cfg.buffer_full) ||
	                 (dr_rd && cfg.read_wait) ||
	                 (init_wr && cfg.reset_pending));

	assign HREADYOUT = ready;
	assign HRESP     = 1'b0;

	// Strobes fire once, in the last cycle of the data phase
	assign cfg.buffer_write_en = dr_wr && ready;
	assign cfg.crc_init_en     = init_wr && ready;
	assign cfg.crc_idr_en      = write_en && (haddr_pp == REG_IDR) && ready;
	assign cfg.crc_poly_en     = write_en && (haddr_pp == REG_POL) && ready;
	assign cfg.reset_chain     = write_en && (haddr_pp == REG_CR) && ready && HWDATA[0];

	assign cfg.bus_wr   = HWDATA;
	assign cfg.bus_size = hsize_pp;

	////////////////////////////////////////
	// Control register
	////////////////////////////////////////

	// Bit 0 is a self clearing chain reset and is not stored
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_ff <= 5'h00;
		else if (write_en && (haddr_pp == REG_CR) && ready)
			crc_cr_ff <= HWDATA[7:3];
	end

	assign cfg.crc_poly_size = poly_size_t'(crc_cr_ff[1:0]);
	assign cfg.rev_in_type   = rev_in_t'(crc_cr_ff[3:2]);
	assign cfg.rev_out_type  = crc_cr_ff[4];

	////////////////////////////////////////
	// Read mux
	////////////////////////////////////////

	always_comb
	begin
		case (haddr_pp)
			REG_DR:   HRDATA = cfg.crc_out;
			REG_IDR:  HRDATA = {24'h0, cfg.crc_idr_out};
			REG_CR:   HRDATA = {24'h0, crc_cr_ff, 3'h0};
			REG_INIT: HRDATA = cfg.crc_init_out;
			REG_POL:  HRDATA = cfg.crc_poly_out;
			// Unmapped offsets
			default:  HRDATA = 32'h0;
		endcase
	end

endmodule

// File: hdl/crc_cfg_if.sv
////////////////////////////////////////
// Link between the AHB host interface and the CRC unit
// Write strobes last one cycle and are already qualified by HREADYOUT
////////////////////////////////////////
interface crc_cfg_if import crc_pkg::*; ();

	// Write data straight from HWDATA, valid in the data phase
	logic [31:0] bus_wr;
	// Registered HSIZE, 0 byte, 1 halfword, 2 word
	logic [1:0]  bus_size;

	// Configuration from CR
	poly_size_t  crc_poly_size;
	rev_in_t     rev_in_type;
	logic        rev_out_type;

	// Data phase strobes
	logic        buffer_write_en;
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        reset_chain;

	// Read values
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;

	// Status used to stretch the data phase
	logic        buffer_full;
	logic        read_wait;
	logic        reset_pending;

	modport host (
		output bus_wr, bus_size, crc_poly_size, rev_in_type, rev_out_type,
		output buffer_write_en, crc_init_en, crc_idr_en, crc_poly_en, reset_chain,
		input  crc_out, crc_init_out, crc_poly_out, crc_idr_out,
		input  buffer_full, read_wait, reset_pending
	);

	modport unit (
		input  bus_wr, bus_size, crc_poly_size, rev_in_type, rev_out_type,
		input  buffer_write_en, crc_init_en, crc_idr_en, crc_poly_en, reset_chain,
		output crc_out, crc_init_out, crc_poly_out, crc_idr_out,
		output buffer_full, read_wait, reset_pending
	);

endinterface

// File: hdl/crc_pkg.sv
////////////////////////////////////////
// Shared types for the CRC AHB-Lite slave
// Register offsets are word indexes taken from HADDR[4:2]
// Offsets 3, 6 and 7 are unmapped and read as zero
////////////////////////////////////////
package crc_pkg;

	////////////////////////////////////////
	// AHB-Lite
	////////////////////////////////////////

	// HTRANS encoding
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Register map, word index
	typedef enum logic [2:0] {
		REG_DR   = 3'h0,
		REG_IDR  = 3'h1,
		REG_CR   = 3'h2,
		REG_INIT = 3'h4,
		REG_POL  = 3'h5
	} crc_reg_t;

	////////////////////////////////////////
	// CRC configuration
	////////////////////////////////////////

	// Polynomial width, CR bits 4:3
	typedef enum logic [1:0] {
		POLY_32 = 2'b00,
		POLY_16 = 2'b01,
		POLY_8  = 2'b10,
		POLY_7  = 2'b11
	} poly_size_t;

	// Input bit reversal unit, CR bits 6:5
	typedef enum logic [1:0] {
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_t;

	// CRC engine state
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CALC,
		ST_LOAD
	} crc_state_t;

endpackage
